//--- bus_route_select.f
src/axi_pkg.sv
src/addr_map_pkg.sv
src/route_if.sv
src/route_control.sv
src/request_capture.sv
src/addr_decoder.sv
src/transfer_tracker.sv
src/bus_route_select.sv
verification/tb_clock_gen.sv
verification/route_checker.sv
verification/bus_route_select_assertions.sv
verification/bus_route_select_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the route selection testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module bus_route_select_tb -f bus_route_select.f -o sim_bin > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_bin > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

//--- src/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder (
    input  logic [axi_pkg::ADDR_BITS-1:0] addr,
    output addr_map_pkg::slave_e          slave
);

    logic [addr_map_pkg::TAG_BITS-1:0] tag;

    assign tag = addr[axi_pkg::ADDR_BITS-1 -: addr_map_pkg::TAG_BITS];

    // Unmatched addresses fall to the default slave
    always_comb begin
        slave = addr_map_pkg::NONE;
        for (int i = addr_map_pkg::NUM_REGIONS - 1; i >= 0; i--) begin
            if ((tag & addr_map_pkg::REGION_MASK[i]) == addr_map_pkg::REGION_BASE[i]) begin
                slave = addr_map_pkg::slave_e'(4'(i));   // Lowest region wins
            end
        end
    end

endmodule

//--- src/addr_map_pkg.sv
package addr_map_pkg;

    // Slave numbers, NONE is the default slave
    typedef enum logic [3:0] {
        ROM   = 4'd0,
        IM    = 4'd1,
        DM    = 4'd2,
        SCTRL = 4'd3,
        WDT   = 4'd4,
        DRAM  = 4'd5,
        EPU   = 4'd6,
        DMA   = 4'd7,
        NONE  = 4'd8
    } slave_e;

    parameter int NUM_REGIONS = 8;
    parameter int TAG_BITS    = 16;   // Upper address bits looked at

    // Region base per slave, indexed by slave number
    parameter logic [TAG_BITS-1:0] REGION_BASE [NUM_REGIONS] = '{
        16'h0000, 16'h0001, 16'h0002, 16'h1000,
        16'h1001, 16'h2000, 16'h0010, 16'h0003
    };

    // Which tag bits take part in the compare
    parameter logic [TAG_BITS-1:0] REGION_MASK [NUM_REGIONS] = '{
        16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF,
        16'hFFFF, 16'hFF00, 16'hFFFF, 16'hFFFF   // DRAM spans 0x20xx_xxxx
    };

endpackage

//--- src/axi_pkg.sv
package axi_pkg;

    // Bus field widths
    parameter int ADDR_BITS = 32;
    parameter int LEN_BITS  = 4;    // ARLEN, beats minus one

    // Masters on the interconnect
    parameter int NUM_MASTERS = 3;
    parameter int MASTER_BITS = 2;

    // M0 is the instruction fetch port, M1 and M2 also write
    typedef enum logic [MASTER_BITS-1:0] {
        M0 = 2'd0,
        M1 = 2'd1,
        M2 = 2'd2
    } master_e;

endpackage

//--- src/bus_route_select.sv
`timescale 1ns/1ps

module bus_route_select #(
    parameter int NUM_MASTERS = axi_pkg::NUM_MASTERS
) (
    input  logic                                            ACLK,
    input  logic                                            ARESETn,
    // Read address and data, per master
    input  logic [NUM_MASTERS-1:0]                          arvalid,
    input  logic [NUM_MASTERS-1:0][axi_pkg::ADDR_BITS-1:0] araddr,
    input  logic [NUM_MASTERS-1:0][axi_pkg::LEN_BITS-1:0]  arlen,
    input  logic [NUM_MASTERS-1:0]                          rvalid,
    input  logic [NUM_MASTERS-1:0]                          rready,
    input  logic [NUM_MASTERS-1:0]                          rlast,
    // Write address and response, M1 and M2
    input  logic [1:0]                                      awvalid,
    input  logic [1:0][axi_pkg::ADDR_BITS-1:0]             awaddr,
    input  logic [1:0]                                      bvalid,
    input  logic [1:0]                                      bready,
    // Route selection
    output logic                                            rd_grant,
    output axi_pkg::master_e                                rd_master,
    output addr_map_pkg::slave_e                            rd_slave,
    output logic                                            wr_grant,
    output axi_pkg::master_e                                wr_master,
    output addr_map_pkg::slave_e                            wr_slave,
    output logic                                            rd_len_error
);

    logic [axi_pkg::ADDR_BITS-1:0] rd_addr;
    logic [axi_pkg::ADDR_BITS-1:0] wr_addr;
    logic [axi_pkg::LEN_BITS-1:0]  rd_len;

    route_if i_route ();

    route_control #(.NUM_MASTERS(NUM_MASTERS)) i_control (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .arvalid  (arvalid),
        .awvalid  (awvalid),
        .ctl      (i_route.ctrl),
        .rd_grant (rd_grant),
        .wr_grant (wr_grant)
    );

    request_capture #(.NUM_MASTERS(NUM_MASTERS)) i_capture (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .araddr  (araddr),
        .arlen   (arlen),
        .awaddr  (awaddr),
        .cap     (i_route.data),
        .rd_addr (rd_addr),
        .rd_len  (rd_len),
        .wr_addr (wr_addr)
    );

    transfer_tracker #(.NUM_MASTERS(NUM_MASTERS)) i_tracker (
        .ACLK         (ACLK),
        .ARESETn      (ARESETn),
        .rvalid       (rvalid),
        .rready       (rready),
        .rlast        (rlast),
        .bvalid       (bvalid),
        .bready       (bready),
        .rd_len       (rd_len),
        .trk          (i_route.data),
        .rd_len_error (rd_len_error)
    );

    // Slave numbers follow the captured addresses
    addr_decoder i_rd_decoder (
        .addr  (rd_addr),
        .slave (rd_slave)
    );

    addr_decoder i_wr_decoder (
        .addr  (wr_addr),
        .slave (wr_slave)
    );

    assign rd_master = i_route.rd_master;
    assign wr_master = i_route.wr_master;

endmodule

//--- src/request_capture.sv
`timescale 1ns/1ps

module request_capture #(
    parameter int NUM_MASTERS = axi_pkg::NUM_MASTERS
) (
    input  logic                                             ACLK,
    input  logic                                             ARESETn,
    input  logic [NUM_MASTERS-1:0][axi_pkg::ADDR_BITS-1:0]  araddr,
    input  logic [NUM_MASTERS-1:0][axi_pkg::LEN_BITS-1:0]   arlen,
    input  logic [1:0][axi_pkg::ADDR_BITS-1:0]              awaddr,   // M1, M2
    route_if.data                                            cap,
    output logic [axi_pkg::ADDR_BITS-1:0]                   rd_addr,
    output logic [axi_pkg::LEN_BITS-1:0]                    rd_len,
    output logic [axi_pkg::ADDR_BITS-1:0]                   wr_addr
);

    logic [axi_pkg::ADDR_BITS-1:0] rd_addr_sel;
    logic [axi_pkg::LEN_BITS-1:0]  rd_len_sel;
    logic [axi_pkg::ADDR_BITS-1:0] wr_addr_sel;

    // Arriving master's request
    assign rd_addr_sel = araddr[cap.rd_master];
    assign rd_len_sel  = arlen[cap.rd_master];

    // Write masters sit one index below their master number
    assign wr_addr_sel = (cap.wr_master == axi_pkg::M2) ? awaddr[1] : awaddr[0];

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            rd_addr <= '0;
            rd_len  <= '0;
        end else if (cap.rd_load) begin
            rd_addr <= rd_addr_sel;
            rd_len  <= rd_len_sel;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wr_addr <= '0;
        end else if (cap.wr_load) begin
            wr_addr <= wr_addr_sel;      // Held for the whole write grant
        end
    end

endmodule

//--- src/route_control.sv
`timescale 1ns/1ps

module route_control #(
    parameter int NUM_MASTERS = axi_pkg::NUM_MASTERS
) (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    input  logic [NUM_MASTERS-1:0] arvalid,
    input  logic [1:0]             awvalid,   // Bit 0 is M1, bit 1 is M2
    route_if.ctrl                  ctl,
    output logic                   rd_grant,
    output logic                   wr_grant
);

    // Held read state carries the owner in its low bits
    typedef enum logic [2:0] {
        RD_IDLE = 3'b000,
        RD_M0   = 3'b100,
        RD_M1   = 3'b101,
        RD_M2   = 3'b110
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_M1   = 2'd1,
        WR_M2   = 2'd2
    } wr_state_e;

    rd_state_e        rd_state;
    wr_state_e        wr_state;
    axi_pkg::master_e rd_pick;
    logic             rd_pick_ok;
    logic             rd_shared;     // Read owned by a master that also writes
    logic             wr_pick_ok;

    // Fixed priority, lowest index wins. M0 is never blocked
    always_comb begin
        rd_pick    = axi_pkg::M0;
        rd_pick_ok = 1'b0;
        for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
            if (arvalid[i] && (i == 0 || wr_state == WR_IDLE)) begin
                rd_pick    = axi_pkg::master_e'(2'(i));
                rd_pick_ok = 1'b1;
            end
        end
    end

    assign ctl.rd_load = (rd_state == RD_IDLE) && rd_pick_ok;

    // Writes wait while M1 or M2 holds or takes the read side
    assign rd_shared  = (rd_state != RD_IDLE && rd_state != RD_M0) ||
                        (ctl.rd_load && rd_pick != axi_pkg::M0);
    assign wr_pick_ok = (|awvalid) && !rd_shared;

    assign ctl.wr_load = (wr_state == WR_IDLE) && wr_pick_ok;

    // While idle the master follows the pick so capture can select by it
    assign ctl.rd_master = (rd_state == RD_IDLE) ? rd_pick
                                                 : axi_pkg::master_e'(rd_state[1:0]);

    always_comb begin
        if (wr_state == WR_IDLE) begin
            ctl.wr_master = awvalid[0] ? axi_pkg::M1 : axi_pkg::M2;   // M1 first
        end else begin
            ctl.wr_master = (wr_state == WR_M2) ? axi_pkg::M2 : axi_pkg::M1;
        end
    end

    assign ctl.rd_active = (rd_state != RD_IDLE);
    assign ctl.wr_active = (wr_state != WR_IDLE);
    assign rd_grant      = ctl.rd_active;
    assign wr_grant      = ctl.wr_active;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            rd_state <= RD_IDLE;
            wr_state <= WR_IDLE;
        end else begin
            if (ctl.rd_load) begin
                rd_state <= rd_state_e'({1'b1, rd_pick});
            end else if (ctl.rd_done) begin
                rd_state <= RD_IDLE;    // Free again next cycle
            end

            if (ctl.wr_load) begin
                wr_state <= (ctl.wr_master == axi_pkg::M1) ? WR_M1 : WR_M2;
            end else if (ctl.wr_done) begin
                wr_state <= WR_IDLE;
            end
        end
    end

endmodule

//--- src/route_if.sv
`timescale 1ns/1ps

interface route_if;

    // Read side grant
    logic             rd_load;     // Pulse, grant taken this cycle
    axi_pkg::master_e rd_master;
    logic             rd_active;   // Level while grant is held
    logic             rd_done;     // Pulse on last read beat

    // Write side grant
    logic             wr_load;
    axi_pkg::master_e wr_master;
    logic             wr_active;
    logic             wr_done;     // Pulse on B handshake

    modport ctrl (
        output rd_load,
        output rd_master,
        output rd_active,
        output wr_load,
        output wr_master,
        output wr_active,
        input  rd_done,
        input  wr_done
    );

    // Capture and tracking blocks
    modport data (
        input  rd_load,
        input  rd_master,
        input  rd_active,
        input  wr_load,
        input  wr_master,
        input  wr_active,
        output rd_done,
        output wr_done
    );

endinterface

//--- src/transfer_tracker.sv
`timescale 1ns/1ps

module transfer_tracker #(
    parameter int NUM_MASTERS = axi_pkg::NUM_MASTERS
) (
    input  logic                          ACLK,
    input  logic                          ARESETn,
    input  logic [NUM_MASTERS-1:0]        rvalid,
    input  logic [NUM_MASTERS-1:0]        rready,
    input  logic [NUM_MASTERS-1:0]        rlast,
    input  logic [1:0]                    bvalid,   // M1, M2
    input  logic [1:0]                    bready,
    input  logic [axi_pkg::LEN_BITS-1:0]  rd_len,
    route_if.data                         trk,
    output logic                          rd_len_error
);

    logic                         load_q;      // rd_len is valid this cycle
    logic [axi_pkg::LEN_BITS-1:0] beats_cnt;
    logic [axi_pkg::LEN_BITS-1:0] beats_left;
    logic                         rd_beat;
    logic                         last_beat;
    logic                         count_end;
    logic                         wr_sel;

    // Captured length arrives one cycle after the load pulse
    assign beats_left = load_q ? rd_len : beats_cnt;

    assign rd_beat   = trk.rd_active && rvalid[trk.rd_master] && rready[trk.rd_master];
    assign last_beat = rlast[trk.rd_master];
    assign count_end = (beats_left == '0);

    assign trk.rd_done = rd_beat && last_beat;   // Early RLAST still ends it

    assign wr_sel      = (trk.wr_master == axi_pkg::M2);
    assign trk.wr_done = trk.wr_active && bvalid[wr_sel] && bready[wr_sel];

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            load_q       <= 1'b0;
            beats_cnt    <= '0;
            rd_len_error <= 1'b0;
        end else begin
            load_q       <= trk.rd_load;
            rd_len_error <= rd_beat && (last_beat != count_end);

            // Overrun beats leave the count parked at zero
            if (rd_beat && !count_end) begin
                beats_cnt <= beats_left - 1'b1;
            end else begin
                beats_cnt <= beats_left;
            end
        end
    end

endmodule

//--- verification/bus_route_select_assertions.sv
`timescale 1ns/1ps

module bus_route_select_assertions (
    input logic                 ACLK,
    input logic                 ARESETn,
    input logic                 rd_grant,
    input logic                 wr_grant,
    input logic                 rd_len_error,
    input axi_pkg::master_e     rd_master,
    input addr_map_pkg::slave_e rd_slave
);

    // Both FSMs idle once reset has been seen
    idle_after_reset: assert property (@(posedge ACLK)
        !ARESETn |=> !rd_grant && !wr_grant && !rd_len_error)
        else $error("grant or length error active after reset");

    route_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        rd_grant |=> !rd_grant || ($stable(rd_master) && $stable(rd_slave)))
        else $error("read route changed during a read grant");

    // Only the fetch port reads alongside a write
    no_shared_read: assert property (@(posedge ACLK) disable iff (!ARESETn)
        wr_grant |-> !rd_grant || rd_master == axi_pkg::M0)
        else $error("M1 or M2 holds the read grant during a write grant");

endmodule

bind bus_route_select bus_route_select_assertions i_assertions (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .rd_grant     (rd_grant),
    .wr_grant     (wr_grant),
    .rd_len_error (rd_len_error),
    .rd_master    (rd_master),
    .rd_slave     (rd_slave)
);

//--- verification/bus_route_select_tb.sv
`timescale 1ns/1ps

module bus_route_select_tb;

    localparam int NM       = axi_pkg::NUM_MASTERS;
    localparam int TIMEOUT  = 100;   // Cycles allowed per wait
    localparam int NUM_ROWS = 17;
    localparam logic [31:0] OTHER_ADDR = 32'h3000_0000;   // Unmapped, for masters not expected to win

    typedef struct packed {
        logic [NM-1:0] ar;       // Read requesters
        logic [31:0]   ra;
        logic [3:0]    len;
        logic [7:0]    beats;    // Beats sent with RLAST on the last
        logic [1:0]    aw;       // Write requesters with bit 0 for M1
        logic [31:0]   wa;
        logic [1:0]    rm;
        logic [3:0]    rs;
        logic [1:0]    wm;
        logic [3:0]    ws;
        logic          err;
    } row_t;

    // ar, rd addr, len, beats, aw, wr addr, then expected rd master/slave, wr master/slave, error
    // Slaves 0 ROM, 1 IM, 2 DM, 3 SCTRL, 4 WDT, 5 DRAM, 6 EPU, 7 DMA, 8 NONE
    row_t rows [NUM_ROWS] = '{
        '{3'b001, 32'h0000_0100, 4'd3, 8'd4, 2'b00, 32'h0, 2'd0, 4'd0, 2'd0, 4'd0, 1'b0},
        '{3'b010, 32'h0001_0040, 4'd0, 8'd1, 2'b00, 32'h0, 2'd1, 4'd1, 2'd0, 4'd0, 1'b0},
        '{3'b100, 32'h0002_0000, 4'd2, 8'd3, 2'b00, 32'h0, 2'd2, 4'd2, 2'd0, 4'd0, 1'b0},
        '{3'b001, 32'h1000_0010, 4'd1, 8'd2, 2'b00, 32'h0, 2'd0, 4'd3, 2'd0, 4'd0, 1'b0},
        '{3'b001, 32'h1001_0000, 4'd1, 8'd2, 2'b00, 32'h0, 2'd0, 4'd4, 2'd0, 4'd0, 1'b0},
        '{3'b010, 32'h20AB_CD00, 4'd7, 8'd8, 2'b00, 32'h0, 2'd1, 4'd5, 2'd0, 4'd0, 1'b0},
        '{3'b100, 32'h0010_0000, 4'd1, 8'd2, 2'b00, 32'h0, 2'd2, 4'd6, 2'd0, 4'd0, 1'b0},
        '{3'b001, 32'h0003_0004, 4'd1, 8'd2, 2'b00, 32'h0, 2'd0, 4'd7, 2'd0, 4'd0, 1'b0},
        '{3'b001, 32'h3000_0000, 4'd0, 8'd1, 2'b00, 32'h0, 2'd0, 4'd8, 2'd0, 4'd0, 1'b0},
        '{3'b111, 32'h0001_0000, 4'd3, 8'd4, 2'b00, 32'h0, 2'd0, 4'd1, 2'd0, 4'd0, 1'b0},
        '{3'b110, 32'h0002_0000, 4'd2, 8'd3, 2'b00, 32'h0, 2'd1, 4'd2, 2'd0, 4'd0, 1'b0},
        '{3'b010, 32'h0000_0000, 4'd3, 8'd2, 2'b00, 32'h0, 2'd1, 4'd0, 2'd0, 4'd0, 1'b1},
        '{3'b100, 32'h0000_0000, 4'd1, 8'd3, 2'b00, 32'h0, 2'd2, 4'd0, 2'd0, 4'd0, 1'b1},
        '{3'b000, 32'h0, 4'd0, 8'd0, 2'b11, 32'h0002_0000, 2'd0, 4'd0, 2'd1, 4'd2, 1'b0},
        '{3'b000, 32'h0, 4'd0, 8'd0, 2'b10, 32'h2000_0000, 2'd0, 4'd0, 2'd2, 4'd5, 1'b0},
        '{3'b001, 32'h0000_0000, 4'd1, 8'd2, 2'b01, 32'h0003_0000, 2'd0, 4'd0, 2'd1, 4'd7, 1'b0},
        '{3'b100, 32'h0001_0000, 4'd1, 8'd2, 2'b01, 32'h1000_0000, 2'd2, 4'd1, 2'd1, 4'd3, 1'b0}
    };

    logic                             ACLK;
    logic                             ARESETn;
    logic [NM-1:0]                    arvalid;
    logic [NM-1:0][31:0]              araddr;
    logic [NM-1:0][3:0]               arlen;
    logic [NM-1:0]                    rvalid;
    logic [NM-1:0]                    rready;
    logic [NM-1:0]                    rlast;
    logic [1:0]                       awvalid;
    logic [1:0][31:0]                 awaddr;
    logic [1:0]                       bvalid;
    logic [1:0]                       bready;
    logic                             rd_grant;
    axi_pkg::master_e                 rd_master;
    addr_map_pkg::slave_e             rd_slave;
    logic                             wr_grant;
    axi_pkg::master_e                 wr_master;
    addr_map_pkg::slave_e             wr_slave;
    logic                             rd_len_error;
    logic                             rd_expected;
    logic                             wr_expected;
    axi_pkg::master_e                 exp_rm;
    addr_map_pkg::slave_e             exp_rs;
    axi_pkg::master_e                 exp_wm;
    addr_map_pkg::slave_e             exp_ws;
    logic                             exp_err;
    logic                             row_end;
    int                               error_count;
    int                               timeouts = 0;
    logic [31:0]                      lcg_state = 32'h1bf24b57;

    tb_clock_gen i_clock (.*);

    bus_route_select #(.NUM_MASTERS(NM)) i_dut (.*);

    route_checker i_checker (.*);

    function automatic logic next_random_bit();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[16];
    endfunction

    task automatic wait_grant(input logic wr, input logic level, input string what);
        int n;
        n = 0;
        do begin
            @(posedge ACLK);
            n++;
        end while (((wr ? wr_grant : rd_grant) != level) && n < TIMEOUT);
        if ((wr ? wr_grant : rd_grant) != level) begin
            $display("Timeout: %s did not reach %0d within %0d cycles", what, level, TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic send_beats(input int m, input int n);
        int            k;
        int            guard;
        logic          rdy;
        logic [NM-1:0] hot;
        k   = 0;
        hot = '0;
        hot[m] = 1'b1;
        for (guard = 0; k < n && guard < TIMEOUT; guard++) begin
            @(posedge ACLK);
            rdy = next_random_bit();      // Random stalls from the master
            rvalid <= hot;
            rready <= rdy ? hot : '0;
            rlast  <= (k == n - 1) ? hot : '0;
            if (rdy) k++;
        end
        @(posedge ACLK);
        rvalid <= '0;
        rready <= '0;
        rlast  <= '0;
        if (k < n) begin
            $display("Timeout: only %0d of %0d read beats were accepted", k, n);
            timeouts++;
        end
    endtask

    task automatic finish_write(input int wm);
        int         guard;
        logic       rdy;
        logic [1:0] own;
        own = (wm == 2) ? 2'b10 : 2'b01;
        @(posedge ACLK);
        bvalid <= ~own;                  // Other master's response must not end the grant
        bready <= ~own;
        rdy = 1'b0;
        for (guard = 0; !rdy && guard < TIMEOUT; guard++) begin
            @(posedge ACLK);
            rdy = next_random_bit();
            bvalid <= own;
            bready <= rdy ? own : 2'b00;
        end
        @(posedge ACLK);
        bvalid <= 2'b00;
        bready <= 2'b00;
        wait_grant(1'b1, 1'b0, "write grant release");
    endtask

    task automatic run_row(input row_t r);
        logic wait_rd;
        int   wr_idx;
        wait_rd = (r.aw != 2'b00) && (r.ar != '0) && !r.ar[0];   // M1 or M2 read behind a write
        wr_idx  = (r.wm == 2'd2) ? 1 : 0;
        @(posedge ACLK);
        exp_rm      <= axi_pkg::master_e'(r.rm);
        exp_rs      <= addr_map_pkg::slave_e'(r.rs);
        exp_wm      <= axi_pkg::master_e'(r.wm);
        exp_ws      <= addr_map_pkg::slave_e'(r.ws);
        exp_err     <= r.err;
        rd_expected <= (r.ar != '0) && !wait_rd;
        wr_expected <= (r.aw != 2'b00);
        // Only the expected owner carries the row's request
        araddr         <= {NM{OTHER_ADDR}};
        araddr[r.rm]   <= r.ra;
        arlen          <= {NM{~r.len}};
        arlen[r.rm]    <= r.len;
        awaddr         <= {2{OTHER_ADDR}};
        awaddr[wr_idx] <= r.wa;
        if (r.aw != 2'b00) begin
            awvalid <= r.aw;
            wait_grant(1'b1, 1'b1, "write grant");
            awvalid <= 2'b00;
        end
        if (r.ar != '0) begin
            arvalid <= r.ar;
            if (wait_rd) begin
                repeat (8) @(posedge ACLK);     // Read stays parked while the write runs
                finish_write(r.wm);
                rd_expected <= 1'b1;
            end
            wait_grant(1'b0, 1'b1, "read grant");
            arvalid <= '0;
            send_beats(r.rm, r.beats);
            wait_grant(1'b0, 1'b0, "read grant release");
        end
        if (r.aw != 2'b00 && !wait_rd) begin
            finish_write(r.wm);
        end
        row_end <= 1'b1;
        @(posedge ACLK);
        row_end <= 1'b0;
    endtask

    initial begin
        int n;
        arvalid     = '0;
        araddr      = '0;
        arlen       = '0;
        rvalid      = '0;
        rready      = '0;
        rlast       = '0;
        awvalid     = '0;
        awaddr      = '0;
        bvalid      = '0;
        bready      = '0;
        rd_expected = 1'b0;
        wr_expected = 1'b0;
        exp_rm      = axi_pkg::M0;
        exp_rs      = addr_map_pkg::NONE;
        exp_wm      = axi_pkg::M1;
        exp_ws      = addr_map_pkg::NONE;
        exp_err     = 1'b0;
        row_end     = 1'b0;
        for (n = 0; !ARESETn && n < TIMEOUT; n++) begin
            @(posedge ACLK);
        end
        if (!ARESETn) begin
            $display("Timeout: reset was never released");
            timeouts++;
        end
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("Rows %0d, errors %0d, timeouts %0d", NUM_ROWS, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verification/route_checker.sv
`timescale 1ns/1ps

module route_checker (
    input  logic                              ACLK,
    input  logic                              ARESETn,
    input  logic                              rd_grant,
    input  axi_pkg::master_e                  rd_master,
    input  addr_map_pkg::slave_e              rd_slave,
    input  logic                              wr_grant,
    input  axi_pkg::master_e                  wr_master,
    input  addr_map_pkg::slave_e              wr_slave,
    input  logic                              rd_len_error,
    input  logic [axi_pkg::NUM_MASTERS-1:0]   rvalid,
    input  logic [axi_pkg::NUM_MASTERS-1:0]   rready,
    input  logic [axi_pkg::NUM_MASTERS-1:0]   rlast,
    input  logic [1:0]                        bvalid,
    input  logic [1:0]                        bready,
    input  logic                              rd_expected,   // A read grant is allowed now
    input  logic                              wr_expected,
    input  axi_pkg::master_e                  exp_rm,
    input  addr_map_pkg::slave_e              exp_rs,
    input  axi_pkg::master_e                  exp_wm,
    input  addr_map_pkg::slave_e              exp_ws,
    input  logic                              exp_err,
    input  logic                              row_end,
    output int                                error_count
);

    int   errors = 0;
    int   wr_own;
    logic rd_grant_q;
    logic wr_grant_q;
    logic rd_end_q;       // Owner's RLAST beat in the last cycle
    logic wr_end_q;
    logic err_seen;

    assign error_count = errors;
    assign wr_own      = (exp_wm == axi_pkg::M2) ? 1 : 0;

    task automatic mismatch(input string name, input int exp, input int act);
        $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        errors++;
    endtask

    task automatic problem(input string what);
        $display("Error at %0t ns: %s", $time, what);
        errors++;
    endtask

    always @(posedge ACLK) begin
        if (!ARESETn) begin
            rd_grant_q <= 1'b0;
            wr_grant_q <= 1'b0;
            rd_end_q   <= 1'b0;
            wr_end_q   <= 1'b0;
            err_seen   <= 1'b0;
        end else begin
            if (rd_grant && !rd_expected) begin
                problem("read grant given while no read should be granted");
            end else if (rd_grant) begin
                if (rd_master !== exp_rm) mismatch("rd_master", exp_rm, rd_master);
                if (rd_slave !== exp_rs) mismatch("rd_slave", exp_rs, rd_slave);
            end
            if (wr_grant && !wr_expected) begin
                problem("write grant given while no write was requested");
            end else if (wr_grant) begin
                if (wr_master !== exp_wm) mismatch("wr_master", exp_wm, wr_master);
                if (wr_slave !== exp_ws) mismatch("wr_slave", exp_ws, wr_slave);
            end
            if (rd_grant_q && !rd_grant && !rd_end_q) begin
                problem("read grant dropped before the owner's last beat");
            end
            if (wr_grant_q && !wr_grant && !wr_end_q) begin
                problem("write grant dropped before the owner's B handshake");
            end
            if (row_end && ((err_seen || rd_len_error) != exp_err)) begin
                mismatch("rd_len_error", exp_err, err_seen || rd_len_error);
            end
            err_seen   <= row_end ? 1'b0 : (err_seen || rd_len_error);
            rd_grant_q <= rd_grant;
            wr_grant_q <= wr_grant;
            rd_end_q   <= rvalid[exp_rm] && rready[exp_rm] && rlast[exp_rm];
            wr_end_q   <= bvalid[wr_own] && bready[wr_own];
        end
    end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic ACLK,
    output logic ARESETn
);

    initial begin
        ACLK = 1'b0;
        forever #(HALF_PERIOD) ACLK = ~ACLK;   // 20 ns period
    end

    initial begin
        ARESETn = 1'b0;
        repeat (RESET_CYCLES) @(posedge ACLK);
        ARESETn <= 1'b1;
    end

endmodule
